//--- build.f
+incdir+hw
hw/mshr_pkg.sv
hw/mshr_intake.sv
hw/mshr_file.sv
hw/mshr_fill_return.sv
hw/mshr_top.sv
testbench/mshr_assert.sv
testbench/mshr_tb.sv

//--- hw/mshr_config.svh
`ifndef MSHR_CONFIG_SVH
`define MSHR_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mshr sizing

// outstanding line misses held at once
`define MSHR_DEPTH 8

// load/store queue slots, one bit per slot in the masks
`define QSLOTS 8

// byte address and offset inside a cache line
`define ADDR_BITS 15
`define LINE_OFFSET_BITS 4

`endif

//--- hw/mshr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_file #(
    parameter int DEPTH = `MSHR_DEPTH
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cur_valid,
    input  wire mshr_pkg::mshr_req_t   cur_req,
    input  wire                        retire,
    output logic                       cur_accept,
    output logic                       alloc_pulse,
    output mshr_pkg::line_addr_t       alloc_line,
    output mshr_pkg::mshr_entry_t      head,
    output logic [$clog2(DEPTH+1)-1:0] count,
    output logic                       full
);
    import mshr_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH+1);

    mshr_entry_t      entries [DEPTH];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [DEPTH-1:0] match;
    logic             hit;
    logic             pop;
    logic [CNT_W-1:0] count_after;
    logic             room;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup, evaluated against the file after this cycle's pop

    assign pop = retire && (count != '0);  // empty file has nothing to pop

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            match[i] = entries[i].valid
                       && !(pop && head_ptr == PTR_W'(i))
                       && entries[i].line == cur_req.line;
        end
    end

    assign hit         = |match;
    assign count_after = count - CNT_W'(pop);
    assign room        = (count_after < CNT_W'(DEPTH));

    assign cur_accept  = cur_valid && (hit || room);
    assign alloc_pulse = cur_valid && !hit && room;
    assign alloc_line  = cur_req.line;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head_ptr].valid <= 1'b0;
            end
            // lines are unique, so at most one entry merges
            for (int i = 0; i < DEPTH; i++) begin
                if (cur_valid && match[i]) begin
                    entries[i].rd_mask <= entries[i].rd_mask | cur_req.rd_mask;
                    entries[i].sw_mask <= entries[i].sw_mask | cur_req.sw_mask;
                end
            end
            // after the pop, so a full file reuses the freed slot
            if (alloc_pulse) begin
                entries[tail_ptr] <= '{
                    valid:   1'b1,
                    line:    cur_req.line,
                    rd_mask: cur_req.rd_mask,
                    sw_mask: cur_req.sw_mask
                };
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // queue pointers

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (pop) begin
                head_ptr <= ptr_inc(head_ptr);
            end
            if (alloc_pulse) begin
                tail_ptr <= ptr_inc(tail_ptr);
            end
            count <= count_after + CNT_W'(alloc_pulse);
        end
    end

    assign head = entries[head_ptr];  // oldest outstanding line
    assign full = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- hw/mshr_fill_return.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_fill_return (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        fill_valid,
    input  wire mshr_pkg::line_addr_t  fill_line,
    input  wire                        alloc_pulse,
    input  wire mshr_pkg::line_addr_t  alloc_line,
    input  wire mshr_pkg::mshr_entry_t head,
    input  wire mshr_pkg::occ_t        count,
    output logic                       retire,
    output logic                       mem_req_valid,
    output mshr_pkg::line_addr_t       mem_req_line,
    output logic                       wakeup_valid,
    output mshr_pkg::wakeup_t          wakeup,
    output logic                       fill_error
);
    import mshr_pkg::*;

    logic       fill_q;
    line_addr_t fill_line_q;
    logic       has_entry;

    // an entry still left once any retire already in flight is done
    assign has_entry = (count > occ_t'(retire));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req_valid <= 1'b0;
            fill_q        <= 1'b0;
            retire        <= 1'b0;
            wakeup_valid  <= 1'b0;
            fill_error    <= 1'b0;
        end else begin
            mem_req_valid <= alloc_pulse;             // one line request per allocation
            fill_q        <= fill_valid;
            retire        <= fill_valid && has_entry;
            wakeup_valid  <= retire;
            // fills come back in order and must name the head line
            fill_error    <= fill_q && (!retire || head.line != fill_line_q);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload

    always_ff @(posedge clk) begin
        if (alloc_pulse) begin
            mem_req_line <= alloc_line;
        end
        if (fill_valid) begin
            fill_line_q <= fill_line;
        end
        if (retire) begin
            wakeup <= '{rd_mask: head.rd_mask, sw_mask: head.sw_mask};  // head about to pop
        end
    end

endmodule

`default_nettype wire

//--- hw/mshr_intake.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_intake (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        req_valid,
    input  wire mshr_pkg::byte_addr_t  req_addr,
    input  wire mshr_pkg::qslot_mask_t req_slot,
    input  wire                        req_is_store,
    input  wire                        cur_accept,
    output logic                       cur_valid,
    output mshr_pkg::mshr_req_t        cur_req,
    output logic                       stall
);
    import mshr_pkg::*;

    intake_state_t state;
    line_addr_t    in_line;
    qslot_mask_t   in_rd_mask;
    qslot_mask_t   in_sw_mask;
    logic          load;

    // line address is the top of the byte address
    assign in_line = req_addr[$bits(byte_addr_t)-1 -: $bits(line_addr_t)];

    // the slot lands in exactly one of the two masks
    assign in_rd_mask = req_is_store ? '0 : req_slot;
    assign in_sw_mask = req_is_store ? req_slot : '0;

    // a new strobe is taken when nothing is pending or the pending one leaves now
    assign load = req_valid && (state == idle || cur_accept);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (req_valid) begin
                        state <= present;
                    end
                end
                present, hold: begin
                    if (cur_accept) begin
                        state <= req_valid ? present : idle;
                    end else begin
                        state <= hold;  // retried every cycle
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cur_req <= '{line: in_line, rd_mask: in_rd_mask, sw_mask: in_sw_mask};
        end
    end

    assign cur_valid = (state != idle);

    // high while the pending request finds no room in the file
    assign stall = cur_valid && !cur_accept;

endmodule

`default_nettype wire

//--- hw/mshr_pkg.sv
`default_nettype none

`include "mshr_config.svh"

package mshr_pkg;

    typedef logic [`ADDR_BITS-1:0]                   byte_addr_t;
    typedef logic [`ADDR_BITS-`LINE_OFFSET_BITS-1:0] line_addr_t;  // upper address bits
    typedef logic [`QSLOTS-1:0]                      qslot_mask_t;
    typedef logic [$clog2(`MSHR_DEPTH+1)-1:0]        occ_t;        // 0 .. depth

    // request after intake, only one of the masks carries the slot
    typedef struct packed {
        line_addr_t  line;
        qslot_mask_t rd_mask;
        qslot_mask_t sw_mask;
    } mshr_req_t;

    typedef struct packed {
        logic        valid;
        line_addr_t  line;
        qslot_mask_t rd_mask;
        qslot_mask_t sw_mask;
    } mshr_entry_t;

    typedef struct packed {
        qslot_mask_t rd_mask;
        qslot_mask_t sw_mask;
    } wakeup_t;

    typedef enum logic [1:0] {
        idle,
        present,
        hold
    } intake_state_t;

endpackage

`default_nettype wire

//--- hw/mshr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        req_valid,
    input  wire mshr_pkg::byte_addr_t  req_addr,
    input  wire mshr_pkg::qslot_mask_t req_slot,
    input  wire                        req_is_store,
    input  wire                        fill_valid,
    input  wire mshr_pkg::line_addr_t  fill_line,
    output logic                       stall,
    output logic                       mem_req_valid,
    output mshr_pkg::line_addr_t       mem_req_line,
    output logic                       wakeup_valid,
    output mshr_pkg::wakeup_t          wakeup,
    output logic                       fill_error,
    output mshr_pkg::occ_t             occupancy,
    output logic                       full
);
    import mshr_pkg::*;

    mshr_req_t   cur_req;
    logic        cur_valid;
    logic        cur_accept;
    logic        alloc_pulse;
    line_addr_t  alloc_line;
    mshr_entry_t head;
    logic        retire;

    mshr_intake i_intake (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_slot     (req_slot),
        .req_is_store (req_is_store),
        .cur_accept   (cur_accept),
        .cur_valid    (cur_valid),
        .cur_req      (cur_req),
        .stall        (stall)
    );

    mshr_file #(
        .DEPTH (`MSHR_DEPTH)
    ) i_file (
        .clk         (clk),
        .rst         (rst),
        .cur_valid   (cur_valid),
        .cur_req     (cur_req),
        .retire      (retire),
        .cur_accept  (cur_accept),
        .alloc_pulse (alloc_pulse),
        .alloc_line  (alloc_line),
        .head        (head),
        .count       (occupancy),  // file count is the occupancy
        .full        (full)
    );

    mshr_fill_return i_fill_return (
        .clk           (clk),
        .rst           (rst),
        .fill_valid    (fill_valid),
        .fill_line     (fill_line),
        .alloc_pulse   (alloc_pulse),
        .alloc_line    (alloc_line),
        .head          (head),
        .count         (occupancy),
        .retire        (retire),
        .mem_req_valid (mem_req_valid),
        .mem_req_line  (mem_req_line),
        .wakeup_valid  (wakeup_valid),
        .wakeup        (wakeup),
        .fill_error    (fill_error)
    );

endmodule

`default_nettype wire

//--- testbench/mshr_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_assert (
    input wire                 clk,
    input wire                 rst,
    input wire                 stall,
    input wire                 cur_valid,
    input wire                 cur_accept,
    input wire                 alloc_pulse,
    input wire                 retire,
    input wire                 full,
    input wire                 mem_req_valid,
    input wire                 wakeup_valid,
    input wire mshr_pkg::occ_t occupancy
);
    import mshr_pkg::*;

    int fail_count = 0;  // failed properties so far

    assert property (@(posedge clk) disable iff (rst) stall |=> cur_valid)
        else begin
            fail_count++;
            $error("stalled request was dropped");
        end

    // room now, or an entry freed by this retire, so nothing may be held back
    assert property (@(posedge clk) disable iff (rst)
                     cur_valid && (!full || retire) |-> cur_accept)
        else begin
            fail_count++;
            $error("pending request refused while the file has room");
        end

    assert property (@(posedge clk) disable iff (rst) occupancy <= `MSHR_DEPTH)
        else begin
            fail_count++;
            $error("occupancy above depth");
        end

    // full file stays full without a pop, or when the freed entry is refilled at once
    assert property (@(posedge clk) disable iff (rst)
                     full && (!retire || alloc_pulse) |=> full)
        else begin
            fail_count++;
            $error("full file count changed without a matching pop");
        end

    assert property (@(posedge clk) disable iff (rst) mem_req_valid |-> occupancy != 0)
        else begin
            fail_count++;
            $error("memory request with an empty file");
        end

    // one wakeup per popped entry
    assert property (@(posedge clk) disable iff (rst)
                     wakeup_valid |-> $past(retire)
                     && occupancy == $past(occupancy) - 1 + $past(alloc_pulse))
        else begin
            fail_count++;
            $error("wakeup without a popped entry");
        end

endmodule

bind mshr_top mshr_assert i_mshr_assert (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .cur_valid     (cur_valid),
    .cur_accept    (cur_accept),
    .alloc_pulse   (alloc_pulse),
    .retire        (retire),
    .full          (full),
    .mem_req_valid (mem_req_valid),
    .wakeup_valid  (wakeup_valid),
    .occupancy     (occupancy)
);

`default_nettype wire

//--- testbench/mshr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_tb;
    import mshr_pkg::*;

    localparam int CLK_NS     = 40;
    localparam int RESET_CYC  = 8;
    localparam int RAND_REQS  = 300;
    localparam int RAND_LINES = 24;
    localparam int N_REQ      = 4 + 4 + 9 + 2 + RAND_REQS;
    localparam int N_FILL     = 4 + 2 + 9 + 3 + RAND_REQS;  // random fills never exceed allocations
    localparam int LIMIT_CYC  = (N_REQ + N_FILL) * 20 + RESET_CYC;

    typedef enum {act_merge, act_alloc, act_reject} action_t;

    // what one fill should produce
    typedef struct packed {
        logic    wake;
        logic    err;
        wakeup_t masks;
    } fill_exp_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    byte_addr_t  req_addr;
    qslot_mask_t req_slot;
    logic        req_is_store;
    logic        fill_valid;
    line_addr_t  fill_line;
    logic        stall;
    logic        mem_req_valid;
    line_addr_t  mem_req_line;
    logic        wakeup_valid;
    wakeup_t     wakeup;
    logic        fill_error;
    occ_t        occupancy;
    logic        full;

    mshr_entry_t model_q[$];  // outstanding lines, oldest first
    logic        held_valid = 1'b0;
    mshr_req_t   held_req;
    line_addr_t  mem_exp[$];
    string       mem_exp_test[$];
    fill_exp_t   fill_exp[$];
    string       fill_exp_test[$];
    int          error_count = 0;
    int          seed = 32'h8415;
    line_addr_t  line_pool[RAND_LINES];

    always #(CLK_NS / 2) clk = ~clk;

    mshr_top i_mshr_top (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_slot      (req_slot),
        .req_is_store  (req_is_store),
        .fill_valid    (fill_valid),
        .fill_line     (fill_line),
        .stall         (stall),
        .mem_req_valid (mem_req_valid),
        .mem_req_line  (mem_req_line),
        .wakeup_valid  (wakeup_valid),
        .wakeup        (wakeup),
        .fill_error    (fill_error),
        .occupancy     (occupancy),
        .full          (full)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model

    function automatic byte_addr_t make_addr(input line_addr_t line,
                                             input logic [`LINE_OFFSET_BITS-1:0] offset);
        return {line, offset};
    endfunction

    function automatic action_t predict_request(input line_addr_t line, output int idx,
                                                output line_addr_t mem_line);
        action_t act;
        idx      = -1;
        mem_line = line;
        for (int i = 0; i < model_q.size(); i++) begin
            if (idx < 0 && model_q[i].line == line) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            act = act_merge;
        end else if (model_q.size() < `MSHR_DEPTH) begin
            act = act_alloc;
        end else begin
            act = act_reject;
        end
        return act;
    endfunction

    function automatic action_t apply_request(input mshr_req_t req, input string test);
        action_t     act;
        int          idx;
        line_addr_t  mem_line;
        mshr_entry_t e;
        act = predict_request(req.line, idx, mem_line);
        if (act == act_merge) begin
            e = model_q[idx];
            e.rd_mask = e.rd_mask | req.rd_mask;
            e.sw_mask = e.sw_mask | req.sw_mask;
            model_q[idx] = e;
        end else if (act == act_alloc) begin
            e.valid   = 1'b1;
            e.line    = req.line;
            e.rd_mask = req.rd_mask;
            e.sw_mask = req.sw_mask;
            model_q.push_back(e);
            mem_exp.push_back(mem_line);
            mem_exp_test.push_back(test);
        end else begin
            held_valid = 1'b1;  // retried once a fill frees an entry
            held_req   = req;
        end
        return act;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and checks

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        assert (expected == actual) else begin
            error_count++;
            $display("[ERROR] %s: %s expected %0h actual %0h", test, what, expected, actual);
        end
    endtask

    task automatic check_occupancy(input string test);
        check_value(test, "occupancy", model_q.size(), occupancy);
        check_value(test, "full", model_q.size() == `MSHR_DEPTH, full);
    endtask

    task automatic send_request(input byte_addr_t addr, input qslot_mask_t slot,
                                input logic is_store, input string test);
        mshr_req_t req;
        action_t   act;
        req.line    = line_addr_t'(addr >> `LINE_OFFSET_BITS);
        req.rd_mask = is_store ? '0 : slot;
        req.sw_mask = is_store ? slot : '0;
        act = apply_request(req, test);
        @(posedge clk);
        req_valid    <= 1'b1;
        req_addr     <= addr;
        req_slot     <= slot;
        req_is_store <= is_store;
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        check_value(test, "stall", act == act_reject, stall);
    endtask

    task automatic send_fill(input line_addr_t line, input string test);
        mshr_entry_t h;
        fill_exp_t   exp;
        exp = '0;
        if (model_q.size() == 0) begin
            exp.err = 1'b1;  // nothing to retire
        end else begin
            h = model_q.pop_front();
            exp.wake          = 1'b1;
            exp.err           = (h.line != line);
            exp.masks.rd_mask = h.rd_mask;
            exp.masks.sw_mask = h.sw_mask;
        end
        fill_exp.push_back(exp);
        fill_exp_test.push_back(test);
        if (held_valid) begin
            held_valid = 1'b0;
            void'(apply_request(held_req, test));
        end
        @(posedge clk);
        fill_valid <= 1'b1;
        fill_line  <= line;
        @(posedge clk);
        fill_valid <= 1'b0;
        @(negedge clk);
        while (!(wakeup_valid || fill_error)) begin
            @(negedge clk);
        end
    endtask

    task automatic run_distinct_misses();
        line_addr_t lines[4] = '{11'h010, 11'h234, 11'h7ff, 11'h001};
        for (int i = 0; i < 4; i++) begin
            send_request(make_addr(lines[i], 4'(i)), qslot_mask_t'(1) << i, 1'b0,
                         "distinct_misses");
        end
        for (int i = 0; i < 4; i++) begin
            send_fill(lines[i], "distinct_misses");
        end
        check_occupancy("distinct_misses");
    endtask

    task automatic run_merge();
        send_request(make_addr(11'h155, 4'h0), 8'h01, 1'b0, "merge");
        send_request(make_addr(11'h155, 4'h6), 8'h08, 1'b1, "merge");
        send_request(make_addr(11'h155, 4'hf), 8'h20, 1'b0, "merge");
        send_request(make_addr(11'h2aa, 4'h3), 8'h02, 1'b1, "merge");
        send_fill(11'h155, "merge");
        send_fill(11'h2aa, "merge");
        check_occupancy("merge");
    endtask

    task automatic run_full_queue();
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            send_request(make_addr(11'h100 + 11'(i * 5), 4'h2), qslot_mask_t'(1) << i, 1'b0,
                         "full_queue");
        end
        @(negedge clk);
        check_occupancy("full_queue");
        send_request(make_addr(11'h1ff, 4'h9), 8'h10, 1'b1, "full_queue");  // ninth line
        repeat (3) @(negedge clk);
        check_value("full_queue", "stall while held", 1, stall);
        send_fill(11'h100, "full_queue");
        check_value("full_queue", "stall after fill", 0, stall);
        check_occupancy("full_queue");
        while (model_q.size() > 0) begin
            send_fill(model_q[0].line, "full_queue");
        end
        check_occupancy("full_queue");
    endtask

    task automatic run_fill_order();
        send_request(make_addr(11'h321, 4'h1), 8'h04, 1'b0, "fill_order");
        send_request(make_addr(11'h654, 4'h8), 8'h80, 1'b1, "fill_order");
        send_fill(11'h0aa, "fill_order");  // not the head line
        send_fill(11'h654, "fill_order");
        send_fill(11'h0aa, "fill_order");  // empty file
        check_occupancy("fill_order");
    endtask

    task automatic run_random_mix();
        int          issued;
        int unsigned r;
        line_addr_t  line;
        issued = 0;
        while (issued < RAND_REQS) begin
            r = $random(seed);
            if (held_valid || (model_q.size() > 0 && r[2:0] < 3)) begin
                send_fill(model_q[0].line, "random_mix");
                check_occupancy("random_mix");
            end else begin
                line = line_pool[(r >> 3) % RAND_LINES];
                send_request(make_addr(line, r[11:8]), qslot_mask_t'(1) << r[14:12], r[15],
                             "random_mix");
                issued++;
            end
        end
        while (model_q.size() > 0) begin
            send_fill(model_q[0].line, "random_mix");
        end
        check_occupancy("random_mix");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output comparison, in event order

    always @(negedge clk) begin
        line_addr_t exp_line;
        fill_exp_t  exp;
        string      test;
        if (!rst && mem_req_valid) begin
            if (mem_exp.size() == 0) begin
                error_count++;
                $display("Unexpected memory request for line %h", mem_req_line);
            end else begin
                exp_line = mem_exp.pop_front();
                test     = mem_exp_test.pop_front();
                assert (mem_req_line == exp_line) else begin
                    error_count++;
                    $display("[ERROR] %s: mem_req_line expected %h actual %h",
                             test, exp_line, mem_req_line);
                end
            end
        end
        if (!rst && (wakeup_valid || fill_error)) begin
            if (fill_exp.size() == 0) begin
                error_count++;
                $display("Unexpected fill result with no fill outstanding");
            end else begin
                exp  = fill_exp.pop_front();
                test = fill_exp_test.pop_front();
                assert (wakeup_valid == exp.wake && fill_error == exp.err
                        && (!exp.wake || wakeup == exp.masks)) else begin
                    error_count++;
                    $display("[ERROR] %s: fill expected wake=%0b err=%0b masks=%h",
                             test, exp.wake, exp.err, exp.masks);
                    $display("[ERROR] %s: fill actual wake=%0b err=%0b masks=%h",
                             test, wakeup_valid, fill_error, wakeup);
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequence and end of run

    initial begin
        rst          <= 1'b1;
        req_valid    <= 1'b0;
        req_addr     <= '0;
        req_slot     <= '0;
        req_is_store <= 1'b0;
        fill_valid   <= 1'b0;
        fill_line    <= '0;
        for (int i = 0; i < RAND_LINES; i++) begin
            line_pool[i] = line_addr_t'(i * 83 + 17);
        end
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset", "stall", 0, stall);
        check_value("reset", "full", 0, full);
        check_value("reset", "wakeup_valid", 0, wakeup_valid);
        check_value("reset", "mem_req_valid", 0, mem_req_valid);
        check_value("reset", "fill_error", 0, fill_error);
        check_value("reset", "occupancy", 0, occupancy);
        run_distinct_misses();
        run_merge();
        run_full_queue();
        run_fill_order();
        run_random_mix();
        repeat (4) @(negedge clk);
        assert (mem_exp.size() == 0 && fill_exp.size() == 0 && !held_valid) else begin
            error_count++;
            $display("Events never appeared: %0d memory requests, %0d fill results",
                     mem_exp.size(), fill_exp.size());
        end
        $display("check errors: %0d, assertion failures: %0d",
                 error_count, i_mshr_top.i_mshr_assert.fail_count);
        if (error_count == 0 && i_mshr_top.i_mshr_assert.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYC * CLK_NS);
        $display("Timeout after %0d cycles, the DUT stopped responding", LIMIT_CYC);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
